//--- des_core.f
+incdir+testbench
source/des_types_pkg.sv
source/des_tables_pkg.sv
source/des_ctrl_if.sv
source/des_sequencer.sv
source/des_key_schedule.sv
source/des_round.sv
source/des_output.sv
source/des_core.sv
testbench/des_core_tb.sv

//--- source/des_core.sv
`timescale 1ns/1ns
`default_nettype none

module des_core #(
    parameter int ROUNDS = des_types_pkg::DES_ROUNDS
) (
    input  wire                       clk_i,
    input  wire                       reset_i,
    input  wire                       mode_i,
    input  wire                       valid_i,
    input  wire                       accept_i,
    input  wire des_types_pkg::des_block_t key_i,
    input  wire des_types_pkg::des_block_t data_i,
    output logic                      accept_o,
    output des_types_pkg::des_block_t data_o_o,
    output logic                      valid_o_o
);

    import des_types_pkg::*;

    des_subkey_t subkey;
    des_block_t  preout;

    des_ctrl_if ctrl ();

    // ==================================================
    // control, datapath, output stage
    // ==================================================
    des_sequencer #(.ROUNDS(ROUNDS)) u_sequencer (
        .clk_i    (clk_i),
        .reset_i  (reset_i),
        .valid_i  (valid_i),
        .mode_i   (mode_i),
        .accept_i (accept_i),
        .accept_o (accept_o),
        .ctrl     (ctrl.seq)
    );

    des_key_schedule u_key_schedule (
        .clk_i    (clk_i),
        .reset_i  (reset_i),
        .key_i    (key_i),
        .ctrl     (ctrl.dp),
        .subkey_o (subkey)
    );

    des_round u_round (
        .clk_i    (clk_i),
        .reset_i  (reset_i),
        .data_i   (data_i),
        .subkey_i (subkey),
        .ctrl     (ctrl.dp),
        .preout_o (preout)
    );

    des_output u_output (
        .clk_i    (clk_i),
        .reset_i  (reset_i),
        .accept_i (accept_i),
        .preout_i (preout),
        .ctrl     (ctrl.res),
        .data_o   (data_o_o),
        .valid_o  (valid_o_o)
    );

endmodule

`default_nettype wire

//--- source/des_ctrl_if.sv
`timescale 1ns/1ns
`default_nettype none

interface des_ctrl_if;

    import des_types_pkg::*;

    logic       load;       // pulse on accepted input
    logic       round_en;   // high for all round cycles
    des_round_t round_idx;
    logic       decrypt;
    logic       finish;     // pulse after the last round

    modport seq (output load, round_en, round_idx, decrypt, finish);

    modport dp (input load, round_en, round_idx, decrypt);

    modport res (input finish);

endinterface

`default_nettype wire

//--- source/des_key_schedule.sv
`timescale 1ns/1ns
`default_nettype none

module des_key_schedule (
    input  wire                        clk_i,
    input  wire                        reset_i,
    input  wire des_types_pkg::des_block_t key_i,
    des_ctrl_if.dp                     ctrl,
    output des_types_pkg::des_subkey_t subkey_o
);

    import des_types_pkg::*;
    import des_tables_pkg::*;

    des_cd_t c_q;
    des_cd_t d_q;
    des_cd_t c_rot;
    des_cd_t d_rot;
    int      shift;

    function automatic des_cd_t rotate(des_cd_t x, logic right, int n);
        if (right) begin
            return (x >> n) | (x << ($bits(des_cd_t) - n));
        end
        return (x << n) | (x >> ($bits(des_cd_t) - n));
    endfunction

    // decrypt walks back from C16/D16, round 1 with no shift
    assign shift = ctrl.decrypt ? DEC_SHIFT[ctrl.round_idx] : ENC_SHIFT[ctrl.round_idx];
    assign c_rot = rotate(c_q, ctrl.decrypt, shift);
    assign d_rot = rotate(d_q, ctrl.decrypt, shift);

    assign subkey_o = des_pc2({c_rot, d_rot});

    always_ff @(posedge clk_i or negedge reset_i) begin
        if (!reset_i) begin
            c_q <= '0;
            d_q <= '0;
        end else if (ctrl.load) begin
            {c_q, d_q} <= des_pc1(key_i);
        end else if (ctrl.round_en) begin
            c_q <= c_rot;
            d_q <= d_rot;
        end
    end

endmodule

`default_nettype wire

//--- source/des_output.sv
`timescale 1ns/1ns
`default_nettype none

module des_output (
    input  wire                       clk_i,
    input  wire                       reset_i,
    input  wire                       accept_i,
    input  wire des_types_pkg::des_block_t preout_i,
    des_ctrl_if.res                   ctrl,
    output des_types_pkg::des_block_t data_o,
    output logic                      valid_o
);

    import des_tables_pkg::*;

    always_ff @(posedge clk_i or negedge reset_i) begin
        if (!reset_i) begin
            data_o  <= '0;
            valid_o <= 1'b0;
        end else if (ctrl.finish) begin
            data_o  <= des_fp(preout_i);
            valid_o <= 1'b1;
        end else if (valid_o && accept_i) begin
            // data stays, only valid drops
            valid_o <= 1'b0;
        end
    end

    a_hold_stall: assert property (@(posedge clk_i) disable iff (!reset_i)
        (valid_o && !accept_i) |=> (valid_o && $stable(data_o)));

endmodule

`default_nettype wire

//--- source/des_round.sv
`timescale 1ns/1ns
`default_nettype none

module des_round (
    input  wire                         clk_i,
    input  wire                         reset_i,
    input  wire des_types_pkg::des_block_t   data_i,
    input  wire des_types_pkg::des_subkey_t  subkey_i,
    des_ctrl_if.dp                      ctrl,
    output des_types_pkg::des_block_t   preout_o
);

    import des_types_pkg::*;
    import des_tables_pkg::*;

    des_half_t l_q;
    des_half_t r_q;
    des_half_t f_out;

    // ==================================================
    // one Feistel round per enabled cycle
    // ==================================================
    assign f_out = des_feistel(r_q, subkey_i);

    always_ff @(posedge clk_i or negedge reset_i) begin
        if (!reset_i) begin
            l_q <= '0;
            r_q <= '0;
        end else if (ctrl.load) begin
            {l_q, r_q} <= des_ip(data_i);
        end else if (ctrl.round_en) begin
            l_q <= r_q;
            r_q <= l_q ^ f_out;
        end
    end

    // halves swapped after round 16
    assign preout_o = {r_q, l_q};

endmodule

`default_nettype wire

//--- source/des_sequencer.sv
`timescale 1ns/1ns
`default_nettype none

module des_sequencer #(
    parameter int ROUNDS = des_types_pkg::DES_ROUNDS
) (
    input  wire  clk_i,
    input  wire  reset_i,
    input  wire  valid_i,
    input  wire  mode_i,
    input  wire  accept_i,
    output logic accept_o,
    des_ctrl_if.seq ctrl
);

    import des_types_pkg::*;

    localparam des_round_t LAST_IDX = des_round_t'(ROUNDS - 1);

    des_seq_state_t state;

    // load is the handshake itself, so L/R and C/D fill at the accepting edge
    assign ctrl.load = valid_i & accept_o;

    always_ff @(posedge clk_i or negedge reset_i) begin
        if (!reset_i) begin
            state          <= IDLE;
            accept_o       <= 1'b0;
            ctrl.round_en  <= 1'b0;
            ctrl.round_idx <= '0;
            ctrl.decrypt   <= 1'b0;
            ctrl.finish    <= 1'b0;
        end else begin
            ctrl.finish <= 1'b0;
            case (state)
                IDLE: begin
                    if (ctrl.load) begin
                        state          <= ROUND;
                        accept_o       <= 1'b0;
                        ctrl.round_en  <= 1'b1;
                        ctrl.round_idx <= '0;
                        ctrl.decrypt   <= mode_i;
                    end else begin
                        accept_o <= 1'b1;
                    end
                end
                ROUND: begin
                    if (ctrl.round_idx == LAST_IDX) begin
                        state         <= DONE;
                        ctrl.round_en <= 1'b0;
                        ctrl.finish   <= 1'b1;
                    end else begin
                        ctrl.round_idx <= ctrl.round_idx + des_round_t'(1);
                    end
                end
                DONE: begin
                    // output valid once finish has passed
                    if (!ctrl.finish && accept_i) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    a_idx_in_range: assert property (@(posedge clk_i) disable iff (!reset_i)
        ctrl.round_en |-> (ctrl.round_idx < ROUNDS));

    a_no_accept_busy: assert property (@(posedge clk_i) disable iff (!reset_i)
        !(accept_o && ctrl.round_en));

endmodule

`default_nettype wire

//--- source/des_tables_pkg.sv
`default_nettype none

package des_tables_pkg;

    import des_types_pkg::*;

    // ==================================================
    // permutation tables, 1-based as in the standard
    // ==================================================
    localparam int IP_TABLE [64] = '{
        58, 50, 42, 34, 26, 18, 10, 2, 60, 52, 44, 36, 28, 20, 12, 4,
        62, 54, 46, 38, 30, 22, 14, 6, 64, 56, 48, 40, 32, 24, 16, 8,
        57, 49, 41, 33, 25, 17, 9, 1, 59, 51, 43, 35, 27, 19, 11, 3,
        61, 53, 45, 37, 29, 21, 13, 5, 63, 55, 47, 39, 31, 23, 15, 7
    };

    localparam int FP_TABLE [64] = '{
        40, 8, 48, 16, 56, 24, 64, 32, 39, 7, 47, 15, 55, 23, 63, 31,
        38, 6, 46, 14, 54, 22, 62, 30, 37, 5, 45, 13, 53, 21, 61, 29,
        36, 4, 44, 12, 52, 20, 60, 28, 35, 3, 43, 11, 51, 19, 59, 27,
        34, 2, 42, 10, 50, 18, 58, 26, 33, 1, 41, 9, 49, 17, 57, 25
    };

    localparam int E_TABLE [48] = '{
        32, 1, 2, 3, 4, 5, 4, 5, 6, 7, 8, 9, 8, 9, 10, 11,
        12, 13, 12, 13, 14, 15, 16, 17, 16, 17, 18, 19, 20, 21, 20, 21,
        22, 23, 24, 25, 24, 25, 26, 27, 28, 29, 28, 29, 30, 31, 32, 1
    };

    localparam int P_TABLE [32] = '{
        16, 7, 20, 21, 29, 12, 28, 17, 1, 15, 23, 26, 5, 18, 31, 10,
        2, 8, 24, 14, 32, 27, 3, 9, 19, 13, 30, 6, 22, 11, 4, 25
    };

    localparam int PC1_TABLE [56] = '{
        57, 49, 41, 33, 25, 17, 9, 1, 58, 50, 42, 34, 26, 18,
        10, 2, 59, 51, 43, 35, 27, 19, 11, 3, 60, 52, 44, 36,
        63, 55, 47, 39, 31, 23, 15, 7, 62, 54, 46, 38, 30, 22,
        14, 6, 61, 53, 45, 37, 29, 21, 13, 5, 28, 20, 12, 4
    };

    localparam int PC2_TABLE [48] = '{
        14, 17, 11, 24, 1, 5, 3, 28, 15, 6, 21, 10, 23, 19, 12, 4,
        26, 8, 16, 7, 27, 20, 13, 2, 41, 52, 31, 37, 47, 55, 30, 40,
        51, 45, 33, 48, 44, 49, 39, 56, 34, 53, 46, 42, 50, 36, 29, 32
    };

    // s-boxes, row-major, index = {b1, b6} * 16 + b2..b5
    localparam int SBOX [8][64] = '{
        '{14, 4, 13, 1, 2, 15, 11, 8, 3, 10, 6, 12, 5, 9, 0, 7,
          0, 15, 7, 4, 14, 2, 13, 1, 10, 6, 12, 11, 9, 5, 3, 8,
          4, 1, 14, 8, 13, 6, 2, 11, 15, 12, 9, 7, 3, 10, 5, 0,
          15, 12, 8, 2, 4, 9, 1, 7, 5, 11, 3, 14, 10, 0, 6, 13},
        '{15, 1, 8, 14, 6, 11, 3, 4, 9, 7, 2, 13, 12, 0, 5, 10,
          3, 13, 4, 7, 15, 2, 8, 14, 12, 0, 1, 10, 6, 9, 11, 5,
          0, 14, 7, 11, 10, 4, 13, 1, 5, 8, 12, 6, 9, 3, 2, 15,
          13, 8, 10, 1, 3, 15, 4, 2, 11, 6, 7, 12, 0, 5, 14, 9},
        '{10, 0, 9, 14, 6, 3, 15, 5, 1, 13, 12, 7, 11, 4, 2, 8,
          13, 7, 0, 9, 3, 4, 6, 10, 2, 8, 5, 14, 12, 11, 15, 1,
          13, 6, 4, 9, 8, 15, 3, 0, 11, 1, 2, 12, 5, 10, 14, 7,
          1, 10, 13, 0, 6, 9, 8, 7, 4, 15, 14, 3, 11, 5, 2, 12},
        '{7, 13, 14, 3, 0, 6, 9, 10, 1, 2, 8, 5, 11, 12, 4, 15,
          13, 8, 11, 5, 6, 15, 0, 3, 4, 7, 2, 12, 1, 10, 14, 9,
          10, 6, 9, 0, 12, 11, 7, 13, 15, 1, 3, 14, 5, 2, 8, 4,
          3, 15, 0, 6, 10, 1, 13, 8, 9, 4, 5, 11, 12, 7, 2, 14},
        '{2, 12, 4, 1, 7, 10, 11, 6, 8, 5, 3, 15, 13, 0, 14, 9,
          14, 11, 2, 12, 4, 7, 13, 1, 5, 0, 15, 10, 3, 9, 8, 6,
          4, 2, 1, 11, 10, 13, 7, 8, 15, 9, 12, 5, 6, 3, 0, 14,
          11, 8, 12, 7, 1, 14, 2, 13, 6, 15, 0, 9, 10, 4, 5, 3},
        '{12, 1, 10, 15, 9, 2, 6, 8, 0, 13, 3, 4, 14, 7, 5, 11,
          10, 15, 4, 2, 7, 12, 9, 5, 6, 1, 13, 14, 0, 11, 3, 8,
          9, 14, 15, 5, 2, 8, 12, 3, 7, 0, 4, 10, 1, 13, 11, 6,
          4, 3, 2, 12, 9, 5, 15, 10, 11, 14, 1, 7, 6, 0, 8, 13},
        '{4, 11, 2, 14, 15, 0, 8, 13, 3, 12, 9, 7, 5, 10, 6, 1,
          13, 0, 11, 7, 4, 9, 1, 10, 14, 3, 5, 12, 2, 15, 8, 6,
          1, 4, 11, 13, 12, 3, 7, 14, 10, 15, 6, 8, 0, 5, 9, 2,
          6, 11, 13, 8, 1, 4, 10, 7, 9, 5, 0, 15, 14, 2, 3, 12},
        '{13, 2, 8, 4, 6, 15, 11, 1, 10, 9, 3, 14, 5, 0, 12, 7,
          1, 15, 13, 8, 10, 3, 7, 4, 12, 5, 6, 11, 0, 14, 9, 2,
          7, 11, 4, 1, 9, 12, 14, 2, 0, 6, 10, 13, 15, 3, 5, 8,
          2, 1, 14, 7, 4, 10, 8, 13, 15, 12, 9, 0, 3, 5, 6, 11}
    };

    // key rotation per round, index 0 is round 1
    localparam int ENC_SHIFT [16] = '{1, 1, 2, 2, 2, 2, 2, 2, 1, 2, 2, 2, 2, 2, 2, 1};
    localparam int DEC_SHIFT [16] = '{0, 1, 2, 2, 2, 2, 2, 2, 1, 2, 2, 2, 2, 2, 2, 1};

    // ==================================================
    // permutation and round functions
    // ==================================================

    // bit n of a w-bit vector sits at index w-n
    function automatic des_block_t des_ip(des_block_t blk);
        des_block_t res;
        for (int i = 0; i < 64; i++) res[63 - i] = blk[64 - IP_TABLE[i]];
        return res;
    endfunction

    function automatic des_block_t des_fp(des_block_t blk);
        des_block_t res;
        for (int i = 0; i < 64; i++) res[63 - i] = blk[64 - FP_TABLE[i]];
        return res;
    endfunction

    // returns {C, D}
    function automatic logic [55:0] des_pc1(des_block_t key);
        logic [55:0] res;
        for (int i = 0; i < 56; i++) res[55 - i] = key[64 - PC1_TABLE[i]];
        return res;
    endfunction

    function automatic des_subkey_t des_pc2(logic [55:0] cd);
        des_subkey_t res;
        for (int i = 0; i < 48; i++) res[47 - i] = cd[56 - PC2_TABLE[i]];
        return res;
    endfunction

    // expansion, key mix, s-boxes, P
    function automatic des_half_t des_feistel(des_half_t r, des_subkey_t k);
        des_subkey_t x;
        des_half_t s;
        des_half_t res;
        logic [5:0] grp;
        int val;
        for (int i = 0; i < 48; i++) x[47 - i] = r[32 - E_TABLE[i]];
        x = x ^ k;
        for (int b = 0; b < 8; b++) begin
            grp = x[47 - 6 * b -: 6];
            val = SBOX[b][{grp[5], grp[0], grp[4:1]}];
            s[31 - 4 * b -: 4] = val[3:0];
        end
        for (int i = 0; i < 32; i++) res[31 - i] = s[32 - P_TABLE[i]];
        return res;
    endfunction

endpackage

`default_nettype wire

//--- source/des_types_pkg.sv
`default_nettype none

package des_types_pkg;

    // ==================================================
    // data widths
    // ==================================================

    // 64-bit data block or raw key, bit 1 of the standard is bit 63
    typedef logic [63:0] des_block_t;

    // L or R half of a block
    typedef logic [31:0] des_half_t;

    // C or D half of the permuted key
    typedef logic [27:0] des_cd_t;

    // per-round subkey after PC-2
    typedef logic [47:0] des_subkey_t;

    // round index, 0 means round 1
    typedef logic [3:0] des_round_t;

    // full DES
    localparam int DES_ROUNDS = 16;

    // ==================================================
    // sequencer FSM
    // ==================================================
    typedef enum logic [1:0] {
        IDLE,
        ROUND,
        DONE
    } des_seq_state_t;

endpackage

`default_nettype wire

//--- testbench/des_vectors.svh
`ifndef DES_VECTORS_SVH
`define DES_VECTORS_SVH

// columns: key, input block, mode (0 encrypt, 1 decrypt), expected output
typedef struct packed {
    des_block_t key;
    des_block_t block;
    logic       mode;
    des_block_t expected;
} des_vector_t;

localparam int NUM_VECTORS = 10;

localparam des_vector_t VECTORS [NUM_VECTORS] = '{
    // encryption
    '{64'h1334_5779_9BBC_DFF1, 64'h0123_4567_89AB_CDEF, 1'b0, 64'h85E8_1354_0F0A_B405},
    '{64'h0E32_9232_EA6D_0D73, 64'h8787_8787_8787_8787, 1'b0, 64'h0000_0000_0000_0000},
    '{64'h0123_4567_89AB_CDEF, 64'h4E6F_7720_6973_2074, 1'b0, 64'h3FA4_0E8A_984D_4815},
    '{64'h0101_0101_0101_0101, 64'h8000_0000_0000_0000, 1'b0, 64'h95F8_A5E5_DD31_D900},
    '{64'h8001_0101_0101_0101, 64'h0000_0000_0000_0000, 1'b0, 64'h95A8_D728_13DA_A94D},
    // decryption of the same rows
    '{64'h1334_5779_9BBC_DFF1, 64'h85E8_1354_0F0A_B405, 1'b1, 64'h0123_4567_89AB_CDEF},
    '{64'h0E32_9232_EA6D_0D73, 64'h0000_0000_0000_0000, 1'b1, 64'h8787_8787_8787_8787},
    '{64'h0123_4567_89AB_CDEF, 64'h3FA4_0E8A_984D_4815, 1'b1, 64'h4E6F_7720_6973_2074},
    '{64'h0101_0101_0101_0101, 64'h95F8_A5E5_DD31_D900, 1'b1, 64'h8000_0000_0000_0000},
    '{64'h8001_0101_0101_0101, 64'h95A8_D728_13DA_A94D, 1'b1, 64'h0000_0000_0000_0000}
};

`endif

//--- testbench/des_core_tb.sv
`timescale 1ns/1ns
`default_nettype none

module des_core_tb;

    import des_types_pkg::*;

    `include "des_vectors.svh"

    localparam int TIMEOUT_CYCLES = 100;
    localparam int LATENCY        = 17;
    localparam int ROUND_TRIPS    = 20;

    logic       clk_i;
    logic       reset_i;
    logic       mode_i;
    logic       valid_i;
    logic       accept_i;
    des_block_t key_i;
    des_block_t data_i;
    logic       accept_o;
    des_block_t data_o_o;
    logic       valid_o_o;

    des_core #(.ROUNDS(DES_ROUNDS)) UUT (
        .clk_i     (clk_i),
        .reset_i   (reset_i),
        .mode_i    (mode_i),
        .valid_i   (valid_i),
        .accept_i  (accept_i),
        .key_i     (key_i),
        .data_i    (data_i),
        .accept_o  (accept_o),
        .data_o_o  (data_o_o),
        .valid_o_o (valid_o_o)
    );

    always #2 clk_i = ~clk_i;

    // ==================================================
    // compare helpers
    // ==================================================
    task automatic abort_run(string reason);
        $display("%s", reason);
        $display("Done: errors found");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic check_block(string name, des_block_t actual, des_block_t expected);
        if (actual !== expected) begin
            abort_run($sformatf("mismatch at %0t ns: %s is %h, expected %h",
                $time, name, actual, expected));
        end
    endtask

    task automatic check_bit(string name, logic actual, logic expected);
        if (actual !== expected) begin
            abort_run($sformatf("mismatch at %0t ns: %s is %b, expected %b",
                $time, name, actual, expected));
        end
    endtask

    task automatic check_latency(int actual, int expected);
        if (actual != expected) begin
            abort_run($sformatf("mismatch at %0t ns: valid_o_o latency is %0d, expected %0d",
                $time, actual, expected));
        end
    endtask

    // ==================================================
    // handshakes
    // ==================================================
    task automatic wait_accept();
        for (int cyc = 0; cyc < TIMEOUT_CYCLES; cyc++) begin
            @(negedge clk_i);
            if (accept_o === 1'b1) break;
        end
        if (accept_o !== 1'b1) begin
            abort_run("timeout: accept_o did not rise within 100 cycles");
        end
    endtask

    // one block through the engine with latency, busy and stall checks
    task automatic run_block(input des_block_t key, input des_block_t block,
                             input logic mode, output des_block_t result);
        des_block_t held;
        int         hold;
        int         cyc;
        wait_accept();
        @(posedge clk_i);
        key_i   <= key;
        data_i  <= block;
        mode_i  <= mode;
        valid_i <= 1'b1;
        // accepting edge
        @(posedge clk_i);
        valid_i <= 1'b0;
        // cyc counts the edges after the accepting one
        for (cyc = 0; cyc < TIMEOUT_CYCLES; cyc++) begin
            @(negedge clk_i);
            check_bit("accept_o", accept_o, 1'b0);
            if (valid_o_o === 1'b1) break;
        end
        if (valid_o_o !== 1'b1) begin
            abort_run("timeout: valid_o_o did not rise within 100 cycles");
        end
        check_latency(cyc, LATENCY);
        held = data_o_o;
        hold = $urandom_range(10, 0);
        repeat (hold) begin
            @(negedge clk_i);
            check_bit("valid_o_o", valid_o_o, 1'b1);
            check_block("data_o_o", data_o_o, held);
            check_bit("accept_o", accept_o, 1'b0);
        end
        @(posedge clk_i);
        accept_i <= 1'b1;
        @(negedge clk_i);
        check_bit("valid_o_o", valid_o_o, 1'b1);
        check_block("data_o_o", data_o_o, held);
        @(posedge clk_i);
        accept_i <= 1'b0;
        @(negedge clk_i);
        check_bit("valid_o_o", valid_o_o, 1'b0);
        result = held;
    endtask

    initial begin
        des_block_t key;
        des_block_t block;
        des_block_t cipher;
        des_block_t result;
        void'($urandom(32'h61fb_ff91));
        clk_i    = 1'b0;
        reset_i  = 1'b0;
        mode_i   = 1'b0;
        valid_i  = 1'b0;
        accept_i = 1'b0;
        key_i    = '0;
        data_i   = '0;

        // outputs quiet while in reset
        repeat (10) begin
            @(negedge clk_i);
            check_bit("valid_o_o", valid_o_o, 1'b0);
            check_block("data_o_o", data_o_o, '0);
            check_bit("accept_o", accept_o, 1'b0);
        end
        @(posedge clk_i);
        reset_i <= 1'b1;
        @(negedge clk_i);
        @(negedge clk_i);
        check_bit("valid_o_o", valid_o_o, 1'b0);
        check_block("data_o_o", data_o_o, '0);

        // known answers
        for (int i = 0; i < NUM_VECTORS; i++) begin
            run_block(VECTORS[i].key, VECTORS[i].block, VECTORS[i].mode, result);
            check_block("data_o_o", result, VECTORS[i].expected);
        end

        // encrypt then decrypt under the same key
        for (int n = 0; n < ROUND_TRIPS; n++) begin
            key   = {$urandom, $urandom};
            block = {$urandom, $urandom};
            run_block(key, block, 1'b0, cipher);
            run_block(key, cipher, 1'b1, result);
            check_block("data_o_o", result, block);
        end

        $display("Done: no errors");
        $finish;
    end

endmodule

`default_nettype wire
